/* common/mist_pkg.sv */
package mist_pkg;

	// frame opcodes, first byte after CONF_DATA0 falls.
	typedef enum logic [7:0] {
		CMD_BUT_SW = 8'h01,
		CMD_JOY0   = 8'h02,
		CMD_JOY1   = 8'h03,
		CMD_KEY    = 8'h05,
		CMD_STATUS = 8'h1e
	} spi_cmd_e;

	typedef struct packed {
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef struct packed {
		logic       pressed;
		logic [7:0] code;
	} key_event_t;

	typedef struct packed {
		logic [26:0] spare_hi;
		logic [1:0]  scanlines;
		logic        rotate;
		logic        spare_lo;
		logic        reset;
	} status_t;

	typedef struct packed {
		logic fire_f;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_t;

	typedef struct packed {
		logic tilt;
		logic coin4;
		logic coin3;
		logic coin2;
		logic coin1;
		logic start4;
		logic start3;
		logic start2;
		logic start1;
	} sys_ctrl_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		logic       blankn;
		logic       hs;
		logic       vs;
	} core_px_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_px_t;

	// ps/2 set 2 scan codes.
	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_LEFT  = 8'h6b;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_LCTRL = 8'h14;
	localparam logic [7:0] KEY_LALT  = 8'h11;
	localparam logic [7:0] KEY_1     = 8'h16;
	localparam logic [7:0] KEY_2     = 8'h1e;
	localparam logic [7:0] KEY_5     = 8'h2e;

endpackage

/* user_io/spi_byte_rx.sv */
`timescale 1ns/100ps

module spi_byte_rx (
	input  logic       clock_12,
	input  logic       rst_n,
	input  logic       sck,
	input  logic       sdi,
	input  logic       ss_n,
	output logic       byte_valid,
	output logic       first_byte,
	output logic [7:0] rx_byte
);

	logic [1:0] sck_sync;
	logic [1:0] sdi_sync;
	logic [1:0] ss_sync;
	logic       sck_d;
	logic       sck_rise;
	logic [2:0] bit_cnt;
	logic [6:0] shift;
	logic       first_pending;

	always_ff @(posedge clock_12) begin
		if (!rst_n) begin
			sck_sync <= 2'b00;
			sdi_sync <= 2'b00;
			ss_sync  <= 2'b11; // deselected.
			sck_d    <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], sck};
			sdi_sync <= {sdi_sync[0], sdi};
			ss_sync  <= {ss_sync[0], ss_n};
			sck_d    <= sck_sync[1];
		end
	end

	assign sck_rise = sck_sync[1] & ~sck_d;

	always_ff @(posedge clock_12) begin
		if (!rst_n) begin
			bit_cnt       <= 3'd0;
			first_pending <= 1'b1;
			byte_valid    <= 1'b0;
			first_byte    <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			if (ss_sync[1]) begin
				// between frames, so the next byte is an opcode.
				bit_cnt       <= 3'd0;
				first_pending <= 1'b1;
			end else if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					byte_valid    <= 1'b1;
					first_byte    <= first_pending;
					first_pending <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock_12) begin
		if (sck_rise && !ss_sync[1]) begin
			shift <= {shift[5:0], sdi_sync[1]}; // msb first.
			if (bit_cnt == 3'd7)
				rx_byte <= {shift, sdi_sync[1]};
		end
	end

endmodule

/* user_io/user_io.sv */
`timescale 1ns/100ps

module user_io import mist_pkg::*; (
	input  logic       clock_12,
	input  logic       rst_n,
	input  logic       sck,
	input  logic       sdi,
	input  logic       ss_n,
	input  logic       key_ack,
	output logic [1:0] buttons,
	output logic [1:0] switches,
	output joy_t       joystick_0,
	output joy_t       joystick_1,
	output status_t    status,
	output key_event_t key_event,
	output logic       key_req
);

	typedef enum logic [1:0] {IDLE, PAYLOAD, DISCARD} state_e;

	state_e      state;
	spi_cmd_e    cmd;
	logic [1:0]  byte_cnt;
	logic [31:0] data_buf;
	logic [31:0] frame_word;
	logic        byte_valid;
	logic        first_byte;
	logic [7:0]  rx_byte;
	logic        payload_byte;
	logic        last_byte;
	logic        key_take;

	function automatic logic [2:0] payload_len(input logic [7:0] op);
		case (op)
			CMD_BUT_SW, CMD_JOY0, CMD_JOY1: payload_len = 3'd1;
			CMD_KEY:                        payload_len = 3'd2;
			CMD_STATUS:                     payload_len = 3'd4;
			default:                        payload_len = 3'd0;
		endcase
	endfunction

	spi_byte_rx u_rx (
		.clock_12  (clock_12),
		.rst_n     (rst_n),
		.sck       (sck),
		.sdi       (sdi),
		.ss_n      (ss_n),
		.byte_valid(byte_valid),
		.first_byte(first_byte),
		.rx_byte   (rx_byte)
	);

	// bytes enter at the top, so the last byte sits in 31:24.
	assign frame_word   = {rx_byte, data_buf[31:8]};
	assign payload_byte = byte_valid && !first_byte && state == PAYLOAD;
	assign last_byte    = ({1'b0, byte_cnt} + 3'd1) == payload_len(cmd);
	// a key frame landing mid-handshake is dropped.
	assign key_take     = payload_byte && last_byte && cmd == CMD_KEY && !key_req && !key_ack;

	always_ff @(posedge clock_12) begin
		if (!rst_n) begin
			state      <= IDLE;
			byte_cnt   <= 2'd0;
			buttons    <= 2'b00;
			switches   <= 2'b00;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			key_req    <= 1'b0;
		end else begin
			if (key_req && key_ack)
				key_req <= 1'b0;
			if (key_take)
				key_req <= 1'b1;
			if (byte_valid && first_byte) begin
				byte_cnt <= 2'd0;
				state    <= (payload_len(rx_byte) != 3'd0) ? PAYLOAD : DISCARD;
			end else if (payload_byte) begin
				byte_cnt <= byte_cnt + 2'd1;
				if (last_byte) begin
					state <= IDLE; // trailing bytes are ignored.
					case (cmd)
						CMD_BUT_SW: begin
							buttons  <= frame_word[25:24];
							switches <= frame_word[27:26];
						end
						CMD_JOY0:   joystick_0 <= frame_word[31:24];
						CMD_JOY1:   joystick_1 <= frame_word[31:24];
						CMD_STATUS: status <= frame_word;
						default: ;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clock_12) begin
		if (byte_valid && first_byte)
			cmd <= spi_cmd_e'(rx_byte);
		if (payload_byte)
			data_buf <= frame_word;
		if (key_take)
			key_event <= '{pressed: frame_word[16], code: frame_word[31:24]}; // flags, then code.
	end

endmodule

/* logic/arcade_inputs.sv */
`timescale 1ns/100ps

module arcade_inputs import mist_pkg::*; (
	input  logic       clock_12,
	input  logic       rst_n,
	input  key_event_t key_event,
	input  logic       key_req,
	input  joy_t       joystick_0,
	input  joy_t       joystick_1,
	input  logic       rotate,
	output logic       key_ack,
	output player_t    player1,
	output player_t    player2,
	output sys_ctrl_t  sys_ctrl
);

	logic      k_up;
	logic      k_down;
	logic      k_left;
	logic      k_right;
	logic      k_fire_a;
	logic      k_fire_b;
	logic      k_start1;
	logic      k_start2;
	logic      k_coin1;
	player_t   p1_merged;
	player_t   p1_next;
	player_t   p2_next;
	sys_ctrl_t ctrl_next;

	always_ff @(posedge clock_12) begin
		if (!rst_n) begin
			key_ack  <= 1'b0;
			k_up     <= 1'b0;
			k_down   <= 1'b0;
			k_left   <= 1'b0;
			k_right  <= 1'b0;
			k_fire_a <= 1'b0;
			k_fire_b <= 1'b0;
			k_start1 <= 1'b0;
			k_start2 <= 1'b0;
			k_coin1  <= 1'b0;
		end else if (key_req && !key_ack) begin
			key_ack <= 1'b1;
			case (key_event.code)
				KEY_UP:    k_up     <= key_event.pressed;
				KEY_DOWN:  k_down   <= key_event.pressed;
				KEY_LEFT:  k_left   <= key_event.pressed;
				KEY_RIGHT: k_right  <= key_event.pressed;
				KEY_LCTRL: k_fire_a <= key_event.pressed;
				KEY_LALT:  k_fire_b <= key_event.pressed;
				KEY_1:     k_start1 <= key_event.pressed;
				KEY_2:     k_start2 <= key_event.pressed;
				KEY_5:     k_coin1  <= key_event.pressed;
				default: ; // acked, no effect.
			endcase
		end else if (!key_req && key_ack) begin
			key_ack <= 1'b0;
		end
	end

	always_comb begin
		p1_merged        = '0;
		p1_merged.right  = joystick_0.right | k_right;
		p1_merged.left   = joystick_0.left | k_left;
		p1_merged.down   = joystick_0.down | k_down;
		p1_merged.up     = joystick_0.up | k_up;
		p1_merged.fire_a = joystick_0.fire_a | k_fire_a;
		p1_merged.fire_b = joystick_0.fire_b | k_fire_b;
		p1_merged.fire_c = joystick_0.fire_c;
		p1_merged.fire_d = joystick_0.fire_d;

		p1_next = p1_merged;
		if (rotate) begin
			// clockwise turn of the stick.
			p1_next.right = p1_merged.up;
			p1_next.down  = p1_merged.right;
			p1_next.left  = p1_merged.down;
			p1_next.up    = p1_merged.left;
		end

		p2_next        = '0;
		p2_next.right  = joystick_1.right;
		p2_next.left   = joystick_1.left;
		p2_next.down   = joystick_1.down;
		p2_next.up     = joystick_1.up;
		p2_next.fire_a = joystick_1.fire_a;
		p2_next.fire_b = joystick_1.fire_b;
		p2_next.fire_c = joystick_1.fire_c;
		p2_next.fire_d = joystick_1.fire_d;

		ctrl_next        = '0;
		ctrl_next.start1 = k_start1;
		ctrl_next.start2 = k_start2;
		ctrl_next.coin1  = k_coin1;
	end

	always_ff @(posedge clock_12) begin
		if (!rst_n) begin
			player1  <= '0;
			player2  <= '0;
			sys_ctrl <= '0;
		end else begin
			player1  <= p1_next;
			player2  <= p2_next;
			sys_ctrl <= ctrl_next;
		end
	end

endmodule

/* logic/video_out.sv */
`timescale 1ns/100ps

module video_out import mist_pkg::*; (
	input  logic       clock_12,
	input  logic       rst_n,
	input  core_px_t   px,
	input  logic [1:0] scanlines,
	output vga_px_t    vga
);

	logic       hs_d;
	logic       line_odd;
	logic       hs_fall;
	logic       odd_now;
	logic [5:0] r_exp;
	logic [5:0] g_exp;
	logic [5:0] b_exp;

	// 1 takes off a quarter, 2 halves, 3 leaves a quarter.
	function automatic logic [5:0] dim(input logic [5:0] c, input logic [1:0] level);
		case (level)
			2'd1:    dim = c - (c >> 2);
			2'd2:    dim = c >> 1;
			2'd3:    dim = c >> 2;
			default: dim = c;
		endcase
	endfunction

	assign hs_fall = hs_d & ~px.hs;
	assign odd_now = line_odd ^ hs_fall; // new line starts with the falling hs.

	always_comb begin
		r_exp = px.blankn ? {px.r, px.r} : 6'd0;
		g_exp = px.blankn ? {px.g, px.g} : 6'd0;
		b_exp = px.blankn ? {px.b, px.b, px.b} : 6'd0;
	end

	always_ff @(posedge clock_12) begin
		if (!rst_n) begin
			hs_d     <= 1'b0;
			line_odd <= 1'b0;
			vga      <= '0;
		end else begin
			hs_d     <= px.hs;
			line_odd <= odd_now;
			vga.r    <= odd_now ? dim(r_exp, scanlines) : r_exp;
			vga.g    <= odd_now ? dim(g_exp, scanlines) : g_exp;
			vga.b    <= odd_now ? dim(b_exp, scanlines) : b_exp;
			vga.hs   <= px.hs;
			vga.vs   <= px.vs;
		end
	end

endmodule

/* logic/sigma_delta_dac.sv */
`timescale 1ns/100ps

module sigma_delta_dac #(
	parameter int DAC_BITS = 16
) (
	input  logic                       clock_12,
	input  logic                       rst_n,
	input  logic signed [DAC_BITS-1:0] sample,
	output logic                       dout
);

	logic [DAC_BITS-1:0] offset;
	logic [DAC_BITS:0]   acc;

	// flip the sign bit for offset binary.
	assign offset = {~sample[DAC_BITS-1], sample[DAC_BITS-2:0]};

	always_ff @(posedge clock_12) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[DAC_BITS-1:0]} + {1'b0, offset};
	end

	assign dout = acc[DAC_BITS]; // carry out is the pulse stream.

endmodule

/* logic/arcade_shell.sv */
`timescale 1ns/100ps

module arcade_shell import mist_pkg::*; #(
	localparam int DAC_BITS = 16
) (
	input  logic                       clock_12,
	input  logic                       rst_n,
	input  logic                       SPI_SCK,
	input  logic                       SPI_DI,
	input  logic                       CONF_DATA0,
	input  core_px_t                   core_px,
	input  logic signed [DAC_BITS-1:0] core_audio,
	output logic [5:0]                 VGA_R,
	output logic [5:0]                 VGA_G,
	output logic [5:0]                 VGA_B,
	output logic                       VGA_HS,
	output logic                       VGA_VS,
	output logic                       AUDIO_L,
	output logic                       AUDIO_R,
	output logic                       LED,
	output player_t                    player1,
	output player_t                    player2,
	output sys_ctrl_t                  sys_ctrl,
	output logic                       core_reset
);

	logic [1:0] buttons;
	joy_t       joystick_0;
	joy_t       joystick_1;
	status_t    status;
	key_event_t key_event;
	logic       key_req;
	logic       key_ack;
	vga_px_t    vga;

	assign LED     = 1'b1;
	assign AUDIO_R = AUDIO_L;

	user_io u_user_io (
		.clock_12  (clock_12),
		.rst_n     (rst_n),
		.sck       (SPI_SCK),
		.sdi       (SPI_DI),
		.ss_n      (CONF_DATA0),
		.key_ack   (key_ack),
		.buttons   (buttons),
		.switches  (),
		.joystick_0(joystick_0),
		.joystick_1(joystick_1),
		.status    (status),
		.key_event (key_event),
		.key_req   (key_req)
	);

	arcade_inputs u_inputs (
		.clock_12  (clock_12),
		.rst_n     (rst_n),
		.key_event (key_event),
		.key_req   (key_req),
		.joystick_0(joystick_0),
		.joystick_1(joystick_1),
		.rotate    (status.rotate),
		.key_ack   (key_ack),
		.player1   (player1),
		.player2   (player2),
		.sys_ctrl  (sys_ctrl)
	);

	video_out u_video (
		.clock_12 (clock_12),
		.rst_n    (rst_n),
		.px       (core_px),
		.scanlines(status.scanlines),
		.vga      (vga)
	);

	assign VGA_R  = vga.r;
	assign VGA_G  = vga.g;
	assign VGA_B  = vga.b;
	assign VGA_HS = vga.hs;
	assign VGA_VS = vga.vs;

	sigma_delta_dac #(
		.DAC_BITS(DAC_BITS)
	) u_dac (
		.clock_12(clock_12),
		.rst_n   (rst_n),
		.sample  (core_audio),
		.dout    (AUDIO_L)
	);

	// core held in reset by the OSD toggle or the board button.
	always_ff @(posedge clock_12) begin
		if (!rst_n)
			core_reset <= 1'b1;
		else
			core_reset <= status.reset | buttons[1];
	end

endmodule

/* sim/arcade_shell_checker.sv */
`timescale 1ns/100ps

module arcade_shell_checker import mist_pkg::*; (
	input logic       clock_12,
	input logic       rst_n,
	input logic       key_req,
	input logic       key_ack,
	input key_event_t key_event
);

	int fail_count = 0;

	// synchronous reset, so the idle state shows on the following edge.
	reset_idle: assert property (@(posedge clock_12) !rst_n |=> (!key_req && !key_ack))
		else begin
			fail_count++;
			$error("key_req or key_ack not cleared by reset");
		end

	ack_needs_req: assert property (@(posedge clock_12) disable iff (!rst_n)
		$rose(key_ack) |-> key_req)
		else begin
			fail_count++;
			$error("key_ack rose without key_req");
		end

	req_held: assert property (@(posedge clock_12) disable iff (!rst_n)
		(key_req && !key_ack) |=> key_req)
		else begin
			fail_count++;
			$error("key_req dropped before key_ack");
		end

	event_stable: assert property (@(posedge clock_12) disable iff (!rst_n)
		(key_req || key_ack) |=> $stable(key_event))
		else begin
			fail_count++;
			$error("key_event changed during the handshake");
		end

	ack_drop: assert property (@(posedge clock_12) disable iff (!rst_n)
		$fell(key_ack) |-> !$past(key_req))
		else begin
			fail_count++;
			$error("key_ack fell while key_req was high");
		end

endmodule

bind arcade_shell arcade_shell_checker chk0 (
	.clock_12 (clock_12),
	.rst_n    (rst_n),
	.key_req  (key_req),
	.key_ack  (key_ack),
	.key_event(key_event)
);

/* sim/tb_arcade_shell.sv */
`timescale 1ns/100ps

module tb_arcade_shell import mist_pkg::*; ();

	typedef struct packed {
		logic [7:0]  op;
		logic [2:0]  len;
		logic [31:0] data; // byte 0 of the payload goes out first.
		player_t     p1;
		player_t     p2;
		sys_ctrl_t   ctrl;
		logic        rst;
	} step_t;

	logic               clock_12;
	logic               rst_n;
	logic               SPI_SCK;
	logic               SPI_DI;
	logic               CONF_DATA0;
	core_px_t           core_px;
	logic signed [15:0] core_audio;
	logic [5:0]         VGA_R;
	logic [5:0]         VGA_G;
	logic [5:0]         VGA_B;
	logic               VGA_HS;
	logic               VGA_VS;
	logic               AUDIO_L;
	logic               AUDIO_R;
	logic               LED;
	player_t            player1;
	player_t            player2;
	sys_ctrl_t          sys_ctrl;
	logic               core_reset;

	step_t       steps[$];
	logic [31:0] lfsr;
	int          errors;
	int          checks;
	logic        model_hs;
	logic        model_odd;

	arcade_shell dut0 (.*);

	always #5 clock_12 = ~clock_12;

	task automatic tick(input int n);
		repeat (n) @(posedge clock_12);
		#1;
	endtask

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        lsb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lsb  = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb)
				lfsr = lfsr ^ 32'h8020_0003;
			v = {v[30:0], lsb};
		end
		return v;
	endfunction

	task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic send_byte(input logic [7:0] v);
		for (int b = 7; b >= 0; b--) begin
			SPI_SCK = 1'b0;
			SPI_DI  = v[b];
			tick(4);
			SPI_SCK = 1'b1; // sampled on this rising edge.
			tick(4);
		end
	endtask

	task automatic send_frame(input logic [7:0] op, input int len, input logic [31:0] data);
		CONF_DATA0 = 1'b0;
		tick(4);
		send_byte(op);
		for (int i = 0; i < len; i++)
			send_byte(data[8*i +: 8]);
		SPI_SCK = 1'b0;
		tick(4);
		CONF_DATA0 = 1'b1;
		tick(20);
	endtask

	task automatic add_step(input logic [7:0] op, input int len, input logic [31:0] data,
			input player_t p1, input player_t p2, input sys_ctrl_t ctrl, input logic rst);
		steps.push_back('{op, len[2:0], data, p1, p2, ctrl, rst});
	endtask

	task automatic load_table();
		add_step(CMD_JOY0,   1, 32'h11,   10'h011, 10'h000, 9'h000, 0);
		add_step(CMD_JOY1,   1, 32'hc6,   10'h011, 10'h0c6, 9'h000, 0);
		add_step(CMD_STATUS, 4, 32'h04,   10'h014, 10'h0c6, 9'h000, 0); // rotate.
		add_step(CMD_JOY0,   1, 32'h08,   10'h001, 10'h0c6, 9'h000, 0);
		add_step(CMD_JOY0,   1, 32'h02,   10'h008, 10'h0c6, 9'h000, 0);
		add_step(CMD_JOY0,   1, 32'h04,   10'h002, 10'h0c6, 9'h000, 0);
		add_step(CMD_STATUS, 4, 32'h00,   10'h004, 10'h0c6, 9'h000, 0);
		add_step(CMD_JOY0,   1, 32'he0,   10'h0e0, 10'h0c6, 9'h000, 0);
		add_step(CMD_JOY0,   1, 32'h00,   10'h000, 10'h0c6, 9'h000, 0);
		add_step(CMD_KEY,    2, 32'h7501, 10'h008, 10'h0c6, 9'h000, 0);
		add_step(CMD_KEY,    2, 32'h1401, 10'h018, 10'h0c6, 9'h000, 0);
		add_step(CMD_KEY,    2, 32'h1601, 10'h018, 10'h0c6, 9'h001, 0);
		add_step(CMD_KEY,    2, 32'h1e01, 10'h018, 10'h0c6, 9'h003, 0);
		add_step(CMD_KEY,    2, 32'h2e01, 10'h018, 10'h0c6, 9'h013, 0);
		add_step(CMD_KEY,    2, 32'h6b01, 10'h01a, 10'h0c6, 9'h013, 0);
		add_step(CMD_KEY,    2, 32'h5501, 10'h01a, 10'h0c6, 9'h013, 0); // unmapped.
		add_step(CMD_KEY,    2, 32'h7500, 10'h012, 10'h0c6, 9'h013, 0);
		add_step(CMD_KEY,    2, 32'h1400, 10'h002, 10'h0c6, 9'h013, 0);
		add_step(CMD_KEY,    2, 32'h6b00, 10'h000, 10'h0c6, 9'h013, 0);
		add_step(CMD_KEY,    2, 32'h7401, 10'h001, 10'h0c6, 9'h013, 0);
		add_step(CMD_KEY,    2, 32'h7201, 10'h005, 10'h0c6, 9'h013, 0);
		add_step(CMD_KEY,    2, 32'h1101, 10'h025, 10'h0c6, 9'h013, 0);
		add_step(CMD_KEY,    2, 32'h7400, 10'h024, 10'h0c6, 9'h013, 0);
		add_step(CMD_KEY,    2, 32'h7200, 10'h020, 10'h0c6, 9'h013, 0);
		add_step(CMD_KEY,    2, 32'h1100, 10'h000, 10'h0c6, 9'h013, 0);
		add_step(CMD_KEY,    2, 32'h1600, 10'h000, 10'h0c6, 9'h012, 0);
		add_step(CMD_KEY,    2, 32'h1e00, 10'h000, 10'h0c6, 9'h010, 0);
		add_step(CMD_KEY,    2, 32'h2e00, 10'h000, 10'h0c6, 9'h000, 0);
		add_step(CMD_STATUS, 4, 32'h01,   10'h000, 10'h0c6, 9'h000, 1);
		add_step(CMD_STATUS, 4, 32'h00,   10'h000, 10'h0c6, 9'h000, 0);
		add_step(CMD_BUT_SW, 1, 32'h02,   10'h000, 10'h0c6, 9'h000, 1);
		add_step(CMD_BUT_SW, 1, 32'h00,   10'h000, 10'h0c6, 9'h000, 0);
		add_step(CMD_JOY1,   1, 32'h39,   10'h000, 10'h039, 9'h000, 0);
		add_step(CMD_JOY1,   1, 32'h00,   10'h000, 10'h000, 9'h000, 0);
	endtask

	task automatic check_step(input int i);
		int n;
		n = 0;
		while (n < 50 && {player1, player2, sys_ctrl, core_reset} !==
				{steps[i].p1, steps[i].p2, steps[i].ctrl, steps[i].rst}) begin
			tick(1);
			n++;
		end
		compare(player1, steps[i].p1, $sformatf("step %0d player1", i));
		compare(player2, steps[i].p2, $sformatf("step %0d player2", i));
		compare(sys_ctrl, steps[i].ctrl, $sformatf("step %0d sys_ctrl", i));
		compare(core_reset, steps[i].rst, $sformatf("step %0d core_reset", i));
	endtask

	function automatic logic [5:0] scale(input logic [5:0] c, input logic [1:0] lvl);
		case (lvl)
			2'd1:    return c - c / 4;
			2'd2:    return c / 2;
			2'd3:    return c / 4;
			default: return c;
		endcase
	endfunction

	function automatic vga_px_t expect_vga(input core_px_t p, input logic [1:0] lvl,
			input logic odd);
		vga_px_t v;
		// repeating a 3-bit value twice is times 9, a 2-bit value three times is times 21.
		v.r  = p.blankn ? 6'(9 * p.r) : 6'd0;
		v.g  = p.blankn ? 6'(9 * p.g) : 6'd0;
		v.b  = p.blankn ? 6'(21 * p.b) : 6'd0;
		v.hs = p.hs;
		v.vs = p.vs;
		if (odd) begin
			v.r = scale(v.r, lvl);
			v.g = scale(v.g, lvl);
			v.b = scale(v.b, lvl);
		end
		return v;
	endfunction

	task automatic run_video(input logic [1:0] lvl);
		logic [31:0] bits;
		core_px_t    px;
		vga_px_t     exp;
		send_frame(CMD_STATUS, 4, {27'd0, lvl, 3'b000});
		repeat (256) begin
			bits = rand_bits(11);
			px   = bits[10:0];
			if (model_hs && !px.hs)
				model_odd = ~model_odd; // falling hs opens the next line.
			model_hs = px.hs;
			exp      = expect_vga(px, lvl, model_odd);
			core_px  = px;
			tick(1);
			compare({VGA_R, VGA_G, VGA_B, VGA_HS, VGA_VS}, exp,
				$sformatf("vga at scanlines %0d", lvl));
		end
	endtask

	task automatic run_audio();
		logic [31:0] bits;
		int          expected;
		int          ones;
		int          mirror_bad;
		bits       = rand_bits(16);
		core_audio = bits[15:0];
		expected   = int'($signed(bits[15:0])) + 32768;
		ones       = 0;
		mirror_bad = 0;
		tick(1);
		repeat (65536) begin
			ones += AUDIO_L;
			if (AUDIO_R !== AUDIO_L)
				mirror_bad++;
			tick(1);
		end
		compare(ones, expected, $sformatf("ones for sample %0d", $signed(bits[15:0])));
		compare(mirror_bad, 0, "AUDIO_R mismatch count");
	endtask

	initial begin
		clock_12   = 1'b0;
		rst_n      = 1'b0;
		SPI_SCK    = 1'b0;
		SPI_DI     = 1'b0;
		CONF_DATA0 = 1'b1;
		core_px    = '0;
		core_audio = '0;
		lfsr       = 32'hcce1_9e76;
		errors     = 0;
		checks     = 0;
		model_hs   = 1'b0;
		model_odd  = 1'b0;
		load_table();

		tick(16);
		compare(core_reset, 1'b1, "core_reset during reset");
		compare({player1, player2, sys_ctrl}, '0, "controls during reset");
		compare({VGA_R, VGA_G, VGA_B, VGA_HS, VGA_VS}, '0, "vga during reset");
		rst_n = 1'b1;
		for (int n = 0; n < 50 && core_reset !== 1'b0; n++)
			tick(1);
		checks++;
		assert (core_reset === 1'b0) else begin
			errors++;
			$display("core_reset did not drop within 50 cycles of reset release");
		end
		compare(LED, 1'b1, "LED");

		foreach (steps[i]) begin
			send_frame(steps[i].op, steps[i].len, steps[i].data);
			check_step(i);
		end

		for (int lvl = 0; lvl < 4; lvl++)
			run_video(lvl[1:0]);
		repeat (3) run_audio();

		$display("%0d checks, %0d mismatches, %0d assertion failures",
			checks, errors, dut0.chk0.fail_count);
		if (errors == 0 && dut0.chk0.fail_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* sim.f */
common/mist_pkg.sv
user_io/spi_byte_rx.sv
user_io/user_io.sv
logic/arcade_inputs.sv
logic/video_out.sv
logic/sigma_delta_dac.sv
logic/arcade_shell.sv
sim/arcade_shell_checker.sv
sim/tb_arcade_shell.sv

/* Bender.yml */
package:
  name: arcade_shell

sources:
  - common/mist_pkg.sv
  - user_io/spi_byte_rx.sv
  - user_io/user_io.sv
  - logic/arcade_inputs.sv
  - logic/video_out.sv
  - logic/sigma_delta_dac.sv
  - logic/arcade_shell.sv
  - target: simulation
    files:
      - sim/arcade_shell_checker.sv
      - sim/tb_arcade_shell.sv
